// File: bench/isq_sva.sv
`timescale 1ns/1ns
`default_nettype none

`include "isq_settings.svh"

module isq_sva
   import isq_port_pkg::*;
(
   input logic                    clk_i,
   input logic                    rst_i,
   input logic                    disp_ready_i,
   input logic [`ISQ_DEPTH-1:0]   entry_vld_i,
   input issue_bundle_t           issue_i
);

   // valid bits of the four registered packets
   logic [3:0] vld_bits;

   assign vld_bits = {issue_i[3].valid, issue_i[2].valid, issue_i[1].valid, issue_i[0].valid};

   // two valid packets naming the same slot
   function automatic logic dup_idx(input issue_bundle_t b);
      logic d;
      d = 1'b0;
      for (int a = 0; a < 4; a++)
      begin
         for (int c = a + 1; c < 4; c++)
         begin
            if (b[a].valid && b[c].valid && (b[a].idx == b[c].idx))
            begin
               d = 1'b1;
            end
         end
      end
      return d;
   endfunction

   //////////////////////////////////////////////////
   // properties
   //////////////////////////////////////////////////
   a_uniq_idx: assert property (@(posedge clk_i) disable iff (rst_i) !dup_idx(issue_i))
      else $error("two issue packets carry the same slot index");

   a_full_only: assert property (@(posedge clk_i) disable iff (rst_i)
                                 !disp_ready_i |-> &entry_vld_i)
      else $error("dispatch refused while a slot is free");

   // packets latched on a reset edge are all invalid
   a_reset_quiet: assert property (@(posedge clk_i) rst_i |=> (vld_bits == 4'b0000))
      else $error("issue packet valid during reset");

endmodule

bind isq_top isq_sva u_sva
(
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .disp_ready_i (disp_ready_o),
   .entry_vld_i  (entry_vld),
   .issue_i      (issue_o)
);

`default_nettype wire

// File: bench/isq_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "isq_settings.svh"

module isq_tb
   import isq_inst_pkg::*;
   import isq_port_pkg::*;
();

   // rough upper bound on the length of all tests, the hang limit is a multiple of it
   localparam int TEST_CYCLES = 500;
   localparam int MAX_CYCLES  = 3 * TEST_CYCLES;

   logic                  clk;
   logic                  rst;
   logic                  disp_valid;
   isq_inst_t             disp_inst;
   logic                  disp_ready;
   logic                  wb_valid;
   logic [`PREG_W-1:0]    wb_preg;
   logic [3:0]            fu_rdy;
   issue_bundle_t         issue;

   // reference copy of the queue slots
   logic                  m_vld [`ISQ_DEPTH];
   isq_inst_t             m_inst [`ISQ_DEPTH];

   int                    cyc = 0;
   logic [31:0]           rng;

   isq_top dut
   (
      .clk_i        (clk),
      .rst_i        (rst),
      .disp_valid_i (disp_valid),
      .disp_inst_i  (disp_inst),
      .disp_ready_o (disp_ready),
      .wb_valid_i   (wb_valid),
      .wb_preg_i    (wb_preg),
      .fu_rdy_i     (fu_rdy),
      .issue_o      (issue)
   );

   // 40 ns period
   always #20 clk = ~clk;

   // hang guard
   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      if (cyc >= MAX_CYCLES)
      begin
         $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // steering rule, slot index only matters for adds
   function automatic int port_for(input isq_op_e op, input int slot);
      int p;
      case (op)
         op_mul:  p = int'(port_mul);
         op_br:   p = int'(port_alu1);
         op_add:  p = ((slot % 3) == 0) ? int'(port_alu1) : int'(port_alu2);
         default: p = int'(port_agu);
      endcase
      return p;
   endfunction

   function automatic isq_inst_t make_inst(input isq_op_e op,
                                           input logic [`PREG_W-1:0] s1, input logic r1,
                                           input logic [`PREG_W-1:0] s2, input logic r2,
                                           input logic [`PREG_W-1:0] d);
      isq_inst_t i;
      i.op       = op;
      i.psrc1    = s1;
      i.src1_rdy = r1;
      i.psrc2    = s2;
      i.src2_rdy = r2;
      i.pdest    = d;
      return i;
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // direct look at one registered packet
   task automatic check_port(input isq_port_e port, input logic vld, input int idx,
                             input int pdest);
      check_val($sformatf("issue_o[%s].valid", port.name()), 32'(vld),
                32'(issue[port].valid));
      if (vld)
      begin
         check_val($sformatf("issue_o[%s].idx", port.name()), 32'(idx),
                   32'(issue[port].idx));
         check_val($sformatf("issue_o[%s].pdest", port.name()), 32'(pdest),
                   32'(issue[port].pdest));
      end
   endtask

   //////////////////////////////////////////////////
   // one clock cycle against the reference queue
   //////////////////////////////////////////////////
   task automatic step(input logic v, input isq_inst_t inst, input logic wbv,
                       input logic [`PREG_W-1:0] wbp, input logic [3:0] fu);
      issue_pkt_t              exp [4];
      logic [`ISQ_DEPTH-1:0]   clr;
      logic                    exp_rdy;
      int                      alloc;
      int                      p;
      isq_inst_t               ninst;
      disp_valid = v;
      disp_inst  = inst;
      wb_valid   = wbv;
      wb_preg    = wbp;
      fu_rdy     = fu;
      clr        = '0;
      for (int k = 0; k < 4; k++)
      begin
         exp[k] = '0;
      end
      // oldest slot number first, one grant per port
      for (int s = 0; s < `ISQ_DEPTH; s++)
      begin
         if (m_vld[s] && m_inst[s].src1_rdy && m_inst[s].src2_rdy)
         begin
            p = port_for(m_inst[s].op, s);
            if (fu[p] && !exp[p].valid)
            begin
               exp[p].valid = 1'b1;
               exp[p].idx   = `ISQ_IDX_W'(s);
               exp[p].op    = m_inst[s].op;
               exp[p].psrc1 = m_inst[s].psrc1;
               exp[p].psrc2 = m_inst[s].psrc2;
               exp[p].pdest = m_inst[s].pdest;
               clr[s]       = 1'b1;
            end
         end
      end
      // a slot freed by this cycle's issue is already usable
      exp_rdy = 1'b0;
      alloc   = 0;
      for (int s = `ISQ_DEPTH-1; s >= 0; s--)
      begin
         if (!m_vld[s] || clr[s])
         begin
            exp_rdy = 1'b1;
            alloc   = s;
         end
      end
      @(negedge clk);
      check_val("disp_ready_o", 32'(exp_rdy), 32'(disp_ready));
      @(posedge clk);
      #1;
      for (int k = 0; k < 4; k++)
      begin
         check_val($sformatf("issue_o[%0d].valid", k), 32'(exp[k].valid),
                   32'(issue[k].valid));
         if (exp[k].valid)
         begin
            check_val($sformatf("issue_o[%0d] payload", k), 32'(exp[k][22:0]),
                      32'(issue[k][22:0]));
         end
      end
      // wakeup and issue clears on the stored slots
      for (int s = 0; s < `ISQ_DEPTH; s++)
      begin
         if (m_vld[s] && wbv && (m_inst[s].psrc1 == wbp))
         begin
            m_inst[s].src1_rdy = 1'b1;
         end
         if (m_vld[s] && wbv && (m_inst[s].psrc2 == wbp))
         begin
            m_inst[s].src2_rdy = 1'b1;
         end
         if (clr[s])
         begin
            m_vld[s] = 1'b0;
         end
      end
      if (v && exp_rdy)
      begin
         ninst = inst;
         // tag completing in the dispatch cycle
         if (wbv && (inst.psrc1 == wbp))
         begin
            ninst.src1_rdy = 1'b1;
         end
         if (wbv && (inst.psrc2 == wbp))
         begin
            ninst.src2_rdy = 1'b1;
         end
         m_inst[alloc] = ninst;
         m_vld[alloc]  = 1'b1;
      end
   endtask

   task automatic idle(input logic [3:0] fu);
      step(1'b0, '0, 1'b0, '0, fu);
   endtask

   //////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////

   task automatic test_reset_state();
      check_val("disp_ready_o", 32'd1, 32'(disp_ready));
      for (int k = 0; k < 4; k++)
      begin
         check_val($sformatf("issue_o[%0d].valid", k), 32'd0, 32'(issue[k].valid));
      end
   endtask

   task automatic test_ready_add_mul();
      // mul parked in slot 0, add in slot 1 goes to alu 2
      step(1'b1, make_inst(op_mul, 6'd1, 1'b1, 6'd2, 1'b1, 6'd10), 1'b0, '0, 4'b1110);
      step(1'b1, make_inst(op_add, 6'd3, 1'b1, 6'd4, 1'b1, 6'd11), 1'b0, '0, 4'b1110);
      idle(4'b1110);
      check_port(port_alu2, 1'b1, 1, 11);
      idle(4'b1111);
      check_port(port_alu2, 1'b0, 0, 0);
      check_port(port_mul, 1'b1, 0, 10);
      idle(4'b1111);
      check_port(port_mul, 1'b0, 0, 0);
      // add in slot 0 goes to alu 1
      step(1'b1, make_inst(op_add, 6'd5, 1'b1, 6'd6, 1'b1, 6'd12), 1'b0, '0, 4'b1111);
      idle(4'b1111);
      check_port(port_alu1, 1'b1, 0, 12);
      idle(4'b1111);
      check_port(port_alu1, 1'b0, 0, 0);
   endtask

   task automatic test_wakeup();
      step(1'b1, make_inst(op_add, 6'd20, 1'b0, 6'd21, 1'b1, 6'd13), 1'b0, '0, 4'b1111);
      repeat (3)
      begin
         idle(4'b1111);
         check_port(port_alu1, 1'b0, 0, 0);
      end
      // tag 20 completes
      step(1'b0, '0, 1'b1, 6'd20, 4'b1111);
      idle(4'b1111);
      check_port(port_alu1, 1'b1, 0, 13);
      idle(4'b1111);
      check_port(port_alu1, 1'b0, 0, 0);
      // broadcast of src2 in the dispatch cycle itself
      step(1'b1, make_inst(op_ld, 6'd22, 1'b1, 6'd23, 1'b0, 6'd14), 1'b1, 6'd23, 4'b1111);
      idle(4'b1111);
      check_port(port_agu, 1'b1, 0, 14);
      idle(4'b1111);
   endtask

   task automatic test_priority();
      for (int i = 0; i < 5; i++)
      begin
         step(1'b1, make_inst(op_mul, 6'(i), 1'b1, 6'(i + 8), 1'b1, 6'(30 + i)), 1'b0, '0,
              4'b1110);
      end
      // one mul per cycle, lowest slot first
      for (int i = 0; i < 5; i++)
      begin
         idle(4'b1111);
         check_port(port_mul, 1'b1, i, 30 + i);
      end
      idle(4'b1111);
      check_port(port_mul, 1'b0, 0, 0);
   endtask

   task automatic test_full_queue();
      for (int i = 0; i < 8; i++)
      begin
         step(1'b1, make_inst(isq_op_e'(2'(i)), 6'(i), 1'b1, 6'(i), 1'b1, 6'(40 + i)),
              1'b0, '0, 4'b0000);
      end
      // ninth one is refused
      step(1'b1, make_inst(op_add, 6'd1, 1'b1, 6'd2, 1'b1, 6'd50), 1'b0, '0, 4'b0000);
      check_val("disp_ready_o", 32'd0, 32'(disp_ready));
      for (int k = 0; k < 4; k++)
      begin
         check_val($sformatf("issue_o[%0d].valid", k), 32'd0, 32'(issue[k].valid));
      end
      idle(4'b1111);
      check_val("disp_ready_o", 32'd1, 32'(disp_ready));
      repeat (3)
      begin
         idle(4'b1111);
      end
   endtask

   task automatic test_random();
      logic [31:0]   r1;
      logic [31:0]   r2;
      isq_inst_t     inst;
      for (int n = 0; n < 200; n++)
      begin
         r1  = xorshift(rng);
         r2  = xorshift(r1);
         rng = r2;
         // small tag range so broadcasts hit waiting sources
         inst.op       = isq_op_e'(r1[1:0]);
         inst.psrc1    = {3'b000, r1[4:2]};
         inst.src1_rdy = r1[5] | r1[6];
         inst.psrc2    = {3'b000, r1[9:7]};
         inst.src2_rdy = r1[10] | r1[11];
         inst.pdest    = r1[17:12];
         step(r1[18] | r1[19], inst, r1[20], {3'b000, r1[23:21]}, r2[3:0] | r2[7:4]);
      end
      // wake every tag so the queue drains
      for (int t = 0; t < 8; t++)
      begin
         step(1'b0, '0, 1'b1, 6'(t), 4'b1111);
      end
      repeat (4)
      begin
         idle(4'b1111);
      end
   endtask

   initial
   begin
      clk        = 1'b0;
      rst        = 1'b1;
      disp_valid = 1'b0;
      disp_inst  = '0;
      wb_valid   = 1'b0;
      wb_preg    = '0;
      fu_rdy     = '0;
      rng        = 32'hdedf;
      for (int s = 0; s < `ISQ_DEPTH; s++)
      begin
         m_vld[s]  = 1'b0;
         m_inst[s] = '0;
      end
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      test_reset_state();
      test_ready_add_mul();
      test_wakeup();
      test_priority();
      test_full_queue();
      test_random();
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/isq_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "isq_settings.svh"

module isq_array
   import isq_inst_pkg::*;
(
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          alloc_en_i,
   input  logic [`ISQ_IDX_W-1:0]         alloc_idx_i,
   input  isq_inst_t                     disp_inst_i,
   input  logic                          wb_valid_i,
   input  logic [`PREG_W-1:0]            wb_preg_i,
   input  logic [`ISQ_DEPTH-1:0]         clr_mask_i,
   output isq_entry_t [`ISQ_DEPTH-1:0]   entries_o
);

   // slot state, valid bits kept apart from the payload
   logic [`ISQ_DEPTH-1:0]        vld_q;
   isq_inst_t [`ISQ_DEPTH-1:0]   inst_q;

   // one-hot of the slot being written this cycle
   logic [`ISQ_DEPTH-1:0]        alloc_sel;
   // incoming instruction after same-cycle wakeup
   isq_inst_t                    new_inst;
   // per-slot tag hits of the writeback broadcast
   logic [`ISQ_DEPTH-1:0]        hit1;
   logic [`ISQ_DEPTH-1:0]        hit2;

   assign alloc_sel = alloc_en_i ? (`ISQ_DEPTH'(1) << alloc_idx_i) : '0;

   //////////////////////////////////////////////////
   // wakeup
   //////////////////////////////////////////////////

   // a tag completing while the instruction is dispatched
   // must not be missed, fold it in before the write
   always_comb
   begin
      new_inst = disp_inst_i;
      if (wb_valid_i && (disp_inst_i.psrc1 == wb_preg_i))
      begin
         new_inst.src1_rdy = 1'b1;
      end
      if (wb_valid_i && (disp_inst_i.psrc2 == wb_preg_i))
      begin
         new_inst.src2_rdy = 1'b1;
      end
   end

   // compare broadcast tag against every stored source
   always_comb
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         hit1[i] = wb_valid_i && vld_q[i] && (inst_q[i].psrc1 == wb_preg_i);
         hit2[i] = wb_valid_i && vld_q[i] && (inst_q[i].psrc2 == wb_preg_i);
      end
   end

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////

   // valid bits, a new write beats an issue clear on the same slot
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         vld_q <= '0;
      end
      else
      begin
         vld_q <= (vld_q & ~clr_mask_i) | alloc_sel;
      end
   end

   // payload, only written or woken, never cleared
   always_ff @(posedge clk_i)
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         if (alloc_sel[i])
         begin
            inst_q[i] <= new_inst;
         end
         else
         begin
            if (hit1[i])
            begin
               inst_q[i].src1_rdy <= 1'b1;
            end
            if (hit2[i])
            begin
               inst_q[i].src2_rdy <= 1'b1;
            end
         end
      end
   end

   // present slots to select as a packed array
   always_comb
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         entries_o[i].vld  = vld_q[i];
         entries_o[i].inst = inst_q[i];
      end
   end

endmodule

`default_nettype wire

// File: rtl/isq_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

`include "isq_settings.svh"

module isq_dispatch
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   disp_valid_i,
   output logic                   disp_ready_o,
   input  logic [`ISQ_DEPTH-1:0]  entry_vld_i,
   input  logic [`ISQ_DEPTH-1:0]  clr_mask_i,
   output logic                   alloc_en_o,
   output logic [`ISQ_IDX_W-1:0]  alloc_idx_o
);

   // allocation is pure logic on the current occupancy

   // occupancy once this cycle's issued slots are gone
   logic [`ISQ_DEPTH-1:0] occ_next;

   assign occ_next = entry_vld_i & ~clr_mask_i;

   // room exists if any slot ends the cycle empty
   assign disp_ready_o = ~&occ_next;

   //////////////////////////////////////////////////
   // free slot search with lowest index first
   //////////////////////////////////////////////////
   always_comb
   begin
      alloc_idx_o = '0;
      // walk down so the last hit is the lowest free slot
      for (int i = `ISQ_DEPTH-1; i >= 0; i--)
      begin
         if (!occ_next[i])
         begin
            alloc_idx_o = `ISQ_IDX_W'(i);
         end
      end
   end

   // write strobe to the array on every transfer
   assign alloc_en_o = disp_valid_i && disp_ready_o;

endmodule

`default_nettype wire

// File: rtl/isq_inst_pkg.sv
`default_nettype none

`include "isq_settings.svh"

package isq_inst_pkg;

   //////////////////////////////////////////////////
   // instruction side of the issue queue
   //////////////////////////////////////////////////

   // operation class, picks which port may take the entry
   typedef enum logic [1:0]
   {
      op_mul = 2'd0,
      op_add = 2'd1,
      op_br  = 2'd2,
      op_ld  = 2'd3
   } isq_op_e;

   // renamed instruction as it leaves rename
   // src*_rdy set when the producer already wrote back
   typedef struct packed
   {
      isq_op_e              op;
      logic [`PREG_W-1:0]   psrc1;
      logic                 src1_rdy;
      logic [`PREG_W-1:0]   psrc2;
      logic                 src2_rdy;
      logic [`PREG_W-1:0]   pdest;
   } isq_inst_t;

   // one queue slot as seen by select
   typedef struct packed
   {
      logic                 vld;
      isq_inst_t            inst;
   } isq_entry_t;

endpackage

`default_nettype wire

// File: rtl/isq_issue_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "isq_settings.svh"

module isq_issue_regs
   import isq_port_pkg::*;
(
   input  logic            clk_i,
   input  logic            rst_i,
   input  issue_bundle_t   issue_i,
   output issue_bundle_t   issue_o
);

   //////////////////////////////////////////////////
   // stage boundary toward register read
   //////////////////////////////////////////////////

   // new packets load every cycle with no hold
   // a packet is valid for exactly the cycle after its grant
   always_ff @(posedge clk_i)
   begin
      for (int p = 0; p < 4; p++)
      begin
         issue_o[p] <= issue_i[p];
      end
      // reset drops every valid bit
      if (rst_i)
      begin
         for (int p = 0; p < 4; p++)
         begin
            issue_o[p].valid <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/isq_port_pkg.sv
`default_nettype none

`include "isq_settings.svh"

package isq_port_pkg;

   import isq_inst_pkg::*;

   //////////////////////////////////////////////////
   // issue side, one packet per function unit port
   //////////////////////////////////////////////////

   // port order is also the bit order of the fu ready vector
   typedef enum logic [1:0]
   {
      port_mul  = 2'd0,
      port_alu1 = 2'd1,
      port_alu2 = 2'd2,
      port_agu  = 2'd3
   } isq_port_e;

   // packet toward register read
   // idx is the slot the instruction came from
   typedef struct packed
   {
      logic                    valid;
      logic [`ISQ_IDX_W-1:0]   idx;
      isq_op_e                 op;
      logic [`PREG_W-1:0]      psrc1;
      logic [`PREG_W-1:0]      psrc2;
      logic [`PREG_W-1:0]      pdest;
   } issue_pkt_t;

   // all four ports together, index with isq_port_e
   typedef issue_pkt_t [3:0] issue_bundle_t;

endpackage

`default_nettype wire

// File: rtl/isq_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "isq_settings.svh"

module isq_select
   import isq_inst_pkg::*;
   import isq_port_pkg::*;
(
   input  isq_entry_t [`ISQ_DEPTH-1:0]   entries_i,
   input  logic [3:0]                    fu_rdy_i,
   output issue_bundle_t                 issue_o,
   output logic [`ISQ_DEPTH-1:0]         clr_mask_o
);

   // slot valid with both operands available
   logic [`ISQ_DEPTH-1:0]          ops_rdy;
   // request vectors, one row per port
   logic [3:0][`ISQ_DEPTH-1:0]     req;
   // winning slot per port
   logic [3:0][`ISQ_IDX_W-1:0]     pick;

   // lowest set bit of a request vector
   function automatic logic [`ISQ_IDX_W-1:0] lowest_set(input logic [`ISQ_DEPTH-1:0] vec);
      logic [`ISQ_IDX_W-1:0] idx;
      idx = '0;
      for (int i = `ISQ_DEPTH-1; i >= 0; i--)
      begin
         if (vec[i])
         begin
            idx = `ISQ_IDX_W'(i);
         end
      end
      return idx;
   endfunction

   //////////////////////////////////////////////////
   // request qualification
   //////////////////////////////////////////////////
   always_comb
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         ops_rdy[i] = entries_i[i].vld &&
                      entries_i[i].inst.src1_rdy &&
                      entries_i[i].inst.src2_rdy;
      end
   end

   // each op fits exactly one port, so grants never overlap
   always_comb
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         req[port_mul][i]  = ops_rdy[i] && fu_rdy_i[port_mul] &&
                             (entries_i[i].inst.op == op_mul);
         // branches and adds in slots 0, 3, 6 go to alu 1
         req[port_alu1][i] = ops_rdy[i] && fu_rdy_i[port_alu1] &&
                             ((entries_i[i].inst.op == op_br) ||
                              ((entries_i[i].inst.op == op_add) && ((i % 3) == 0)));
         // remaining adds
         req[port_alu2][i] = ops_rdy[i] && fu_rdy_i[port_alu2] &&
                             (entries_i[i].inst.op == op_add) && ((i % 3) != 0);
         req[port_agu][i]  = ops_rdy[i] && fu_rdy_i[port_agu] &&
                             (entries_i[i].inst.op == op_ld);
      end
   end

   //////////////////////////////////////////////////
   // priority pick, packet build, clear mask
   //////////////////////////////////////////////////
   always_comb
   begin
      clr_mask_o = '0;
      for (int p = 0; p < 4; p++)
      begin
         pick[p]    = lowest_set(req[p]);
         // idle port sends an all-zero packet
         issue_o[p] = '0;
         if (|req[p])
         begin
            issue_o[p].valid = 1'b1;
            issue_o[p].idx   = pick[p];
            issue_o[p].op    = entries_i[pick[p]].inst.op;
            issue_o[p].psrc1 = entries_i[pick[p]].inst.psrc1;
            issue_o[p].psrc2 = entries_i[pick[p]].inst.psrc2;
            issue_o[p].pdest = entries_i[pick[p]].inst.pdest;
            // granted slot is freed at the edge
            clr_mask_o[pick[p]] = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/isq_settings.svh
`ifndef ISQ_SETTINGS_SVH
`define ISQ_SETTINGS_SVH

// number of issue queue slots
`define ISQ_DEPTH 8

// width of a slot index, log2 of the depth
`define ISQ_IDX_W 3

// physical register tag width
`define PREG_W 6

`endif

// File: rtl/isq_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "isq_settings.svh"

module isq_top
   import isq_inst_pkg::*;
   import isq_port_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  disp_valid_i,
   input  isq_inst_t             disp_inst_i,
   output logic                  disp_ready_o,
   input  logic                  wb_valid_i,
   input  logic [`PREG_W-1:0]    wb_preg_i,
   input  logic [3:0]            fu_rdy_i,
   output issue_bundle_t         issue_o
);

   // queue contents and their valid bits
   isq_entry_t [`ISQ_DEPTH-1:0]  entries;
   logic [`ISQ_DEPTH-1:0]        entry_vld;
   // slots issued this cycle
   logic [`ISQ_DEPTH-1:0]        clr_mask;
   // allocation strobe and slot
   logic                         alloc_en;
   logic [`ISQ_IDX_W-1:0]        alloc_idx;
   // unregistered select result
   issue_bundle_t                issue_comb;

   // pull the valid bit out of each slot
   for (genvar i = 0; i < `ISQ_DEPTH; i++)
   begin : g_vld
      assign entry_vld[i] = entries[i].vld;
   end

   //////////////////////////////////////////////////
   // input side
   //////////////////////////////////////////////////
   isq_dispatch u_dispatch
   (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .disp_valid_i (disp_valid_i),
      .disp_ready_o (disp_ready_o),
      .entry_vld_i  (entry_vld),
      .clr_mask_i   (clr_mask),
      .alloc_en_o   (alloc_en),
      .alloc_idx_o  (alloc_idx)
   );

   //////////////////////////////////////////////////
   // queue and select
   //////////////////////////////////////////////////
   isq_array u_array
   (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .alloc_en_i  (alloc_en),
      .alloc_idx_i (alloc_idx),
      .disp_inst_i (disp_inst_i),
      .wb_valid_i  (wb_valid_i),
      .wb_preg_i   (wb_preg_i),
      .clr_mask_i  (clr_mask),
      .entries_o   (entries)
   );

   isq_select u_select
   (
      .entries_i  (entries),
      .fu_rdy_i   (fu_rdy_i),
      .issue_o    (issue_comb),
      .clr_mask_o (clr_mask)
   );

   //////////////////////////////////////////////////
   // output side
   //////////////////////////////////////////////////
   isq_issue_regs u_issue_regs
   (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .issue_i (issue_comb),
      .issue_o (issue_o)
   );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the issue queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module isq_tb -f vlog.f -o isq_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/isq_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

// File: vlog.f
+incdir+rtl
rtl/isq_inst_pkg.sv
rtl/isq_port_pkg.sv
rtl/isq_dispatch.sv
rtl/isq_array.sv
rtl/isq_select.sv
rtl/isq_issue_regs.sv
rtl/isq_top.sv
bench/isq_sva.sv
bench/isq_tb.sv
